//--- common/pfPkg.sv
`default_nettype none

package pfPkg;

   ////////////////////////////////////////
   // Page flags
   ////////////////////////////////////////

   // Bit order matches bits 2..0 of a page entry write
   typedef struct packed
   {
      logic valid;       // Entry present
      logic writeable;   // Write test allowed
      logic user;        // User page, else exec page
   } pageFlagsT;

   ////////////////////////////////////////
   // Page fail dispatch codes
   ////////////////////////////////////////

   // Codes the microcode reads back via DP left
   typedef enum logic [3:0]
   {
      dispNone       = 4'd0,
      dispIntr       = 4'd1,     // PI or timer
      dispNxm        = 4'd5,
      dispWriteFail  = 4'd8,     // Write test on read-only page
      dispNotPresent = 4'd10,
      dispMismatch   = 4'd11     // Exec/user mismatch
   } dispCodeT;

   ////////////////////////////////////////
   // APB register map
   ////////////////////////////////////////

   typedef logic [7:0] aprAddrT;

   localparam aprAddrT regAprFlags = 8'h00;
   localparam aprAddrT regDispatch = 8'h04;
   // Page entries at pageBase + 4 * index
   localparam aprAddrT pageBase    = 8'h40;

   // APR flag bit positions
   localparam int aprPageEnBit = 0;

endpackage

`default_nettype wire

//--- common/pagerIf.sv
`timescale 1ns/1ps
`default_nettype none

interface pagerIf;

   import pfPkg::*;

   // Latched access qualifiers
   logic      vmaUser;
   logic      vmaPhys;
   logic      vmaAcRef;
   logic      vmaWrTest;

   // Memory cycle strobe, one enabled cycle after the request
   logic      pfEn;

   // Flags of the latched page
   pageFlagsT pageFlags;

   // VMA latch and page table each drive their own share
   modport source
   (
      output vmaUser, vmaPhys, vmaAcRef, vmaWrTest, pfEn, pageFlags
   );

   // Dispatch only looks
   modport dispatch
   (
      input  vmaUser, vmaPhys, vmaAcRef, vmaWrTest, pfEn, pageFlags
   );

endinterface

`default_nettype wire

//--- source/vmaLatch.sv
`timescale 1ns/1ps
`default_nettype none

module vmaLatch
#(
   parameter int pageBits = 4
)
(
   input  wire                 clk,
   input  wire                 rst,
   input  wire                 clken,
   // Decoded memory cycle bits
   input  wire                 memCycle,
   input  wire                 memFetch,
   input  wire                 memWrTest,
   input  wire                 memPhys,
   input  wire                 memUser,
   input  wire                 memAcRef,
   input  wire [pageBits-1:0]  vmaPage,
   // Latched page number for the table lookup
   output logic [pageBits-1:0] pageIdx,
   // Fetch seen last cycle
   output logic                intrEn,
   pagerIf.source              pb
);

   ////////////////////////////////////////
   // Request strobes
   ////////////////////////////////////////

   // High for the one enabled cycle after a request
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         pb.pfEn <= 1'b0;
         intrEn  <= 1'b0;
      end
      else if (clken)
      begin
         pb.pfEn <= memCycle;
         // Interrupts are only taken after a fetch
         intrEn  <= memCycle & memFetch;
      end
   end

   ////////////////////////////////////////
   // VMA and qualifiers
   ////////////////////////////////////////

   // Held across non-memory cycles
   always_ff @(posedge clk)
   begin
      if (clken && memCycle)
      begin
         pageIdx      <= vmaPage;
         pb.vmaUser   <= memUser;
         pb.vmaPhys   <= memPhys;
         pb.vmaAcRef  <= memAcRef;
         pb.vmaWrTest <= memWrTest;
      end
   end

endmodule

`default_nettype wire

//--- pager/pageTable.sv
`timescale 1ns/1ps
`default_nettype none

module pageTable
#(
   parameter int pageBits = 4
)
(
   input  wire                   clk,
   input  wire                   rst,
   // Lookup index from the VMA latch
   input  wire [pageBits-1:0]    pageIdx,
   // Write port from APB
   input  wire                   tableWe,
   input  wire [pageBits-1:0]    tableIdx,
   input  wire pfPkg::pageFlagsT tableFlags,
   // Drives pageFlags only
   pagerIf.source                pb
);

   import pfPkg::*;

   localparam int numPages = 1 << pageBits;

   // One flag set per virtual page
   pageFlagsT entries [numPages];

   ////////////////////////////////////////
   // Table fill
   ////////////////////////////////////////

   // Cleared entries are not valid
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         for (int i = 0; i < numPages; i++)
            entries[i] <= '0;
      end
      else if (tableWe)
         entries[tableIdx] <= tableFlags;
   end

   ////////////////////////////////////////
   // Lookup
   ////////////////////////////////////////

   // Combinational read at the latched page
   // A write lands at the edge, so the new value shows next cycle
   always_comb
   begin
      pb.pageFlags = entries[pageIdx];
   end

endmodule

`default_nettype wire

//--- source/aprRegs.sv
`timescale 1ns/1ps
`default_nettype none

module aprRegs
#(
   parameter int pageBits = 4
)
(
   input  wire                  clk,
   input  wire                  rst,
   // APB slave
   input  wire                  psel,
   input  wire                  penable,
   input  wire                  pwrite,
   input  wire pfPkg::aprAddrT  paddr,
   input  wire [31:0]           pwdata,
   output logic [31:0]          prdata,
   output logic                 pready,
   // Dispatch readback
   input  wire pfPkg::dispCodeT dispPf,
   // APR flags
   output logic                 pageEnable,
   // Page table write port
   output logic                 tableWe,
   output logic [pageBits-1:0]  tableIdx,
   output pfPkg::pageFlagsT     tableFlags
);

   import pfPkg::*;

   // Bytes covered by the page entries
   localparam int pageSpan = 4 << pageBits;

   logic    wrAccess;
   logic    pageHit;
   aprAddrT pageOff;

   ////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////

   // Write commits in the access phase
   assign wrAccess = psel & penable & pwrite;

   // Offset into the page entry window
   assign pageOff = paddr - pageBase;

   // Word aligned and inside the table, else unmapped
   assign pageHit = (paddr >= pageBase) && (pageOff[1:0] == 2'b00) &&
                    (int'(pageOff) < pageSpan);

   // Never stalls
   assign pready = 1'b1;

   ////////////////////////////////////////
   // Register writes
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         pageEnable <= 1'b0;
      else if (wrAccess && (paddr == regAprFlags))
         pageEnable <= pwdata[aprPageEnBit];
   end

   // Page entry write strobe, one cycle
   assign tableWe    = wrAccess & pageHit;
   assign tableIdx   = pageOff[pageBits+1:2];
   assign tableFlags = pageFlagsT'(pwdata[2:0]);

   ////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////

   // Page entries and unmapped addresses read zero
   always_comb
   begin
      prdata = 32'd0;
      if (psel && !pwrite)
      begin
         case (paddr)
            regAprFlags : prdata[aprPageEnBit] = pageEnable;
            regDispatch : prdata[3:0]          = dispPf;
            default     : prdata               = 32'd0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- dispatch/pageFailDispatch.sv
`timescale 1ns/1ps
`default_nettype none

module pageFailDispatch
(
   input  wire              clk,
   input  wire              rst,
   input  wire              clken,
   // Microcode clears the dispatch register
   input  wire              specMemClr,
   // APR flag
   input  wire              pageEnable,
   // Fetch last cycle
   input  wire              intrEn,
   // Interrupt sources
   input  wire              piIntr,
   input  wire              timerIntr,
   input  wire              nxmIntr,
   pagerIf.dispatch         pb,
   output logic             pageFail,
   output pfPkg::dispCodeT  dispPf
);

   import pfPkg::*;

   dispCodeT dispatch;
   logic     pageChk;

   ////////////////////////////////////////
   // Fault priority
   ////////////////////////////////////////

   // Paging applies to translated, non AC accesses
   assign pageChk = pb.pfEn & pageEnable & ~pb.vmaPhys & ~pb.vmaAcRef;

   // Interrupts first, then page faults
   always_comb
   begin
      pageFail = 1'b0;
      dispatch = dispNone;
      if (intrEn && nxmIntr)
      begin
         pageFail = 1'b1;
         dispatch = dispNxm;
      end
      else if (intrEn && (piIntr || timerIntr))
      begin
         pageFail = 1'b1;
         dispatch = dispIntr;
      end
      // Page not valid
      else if (pageChk && !pb.pageFlags.valid)
      begin
         pageFail = 1'b1;
         dispatch = dispNotPresent;
      end
      // Exec/user mismatch
      else if (pageChk && (pb.vmaUser != pb.pageFlags.user))
      begin
         pageFail = 1'b1;
         dispatch = dispMismatch;
      end
      // Write test on read-only page
      else if (pageChk && pb.vmaWrTest && !pb.pageFlags.writeable)
      begin
         pageFail = 1'b1;
         dispatch = dispWriteFail;
      end
   end

   ////////////////////////////////////////
   // Dispatch register
   ////////////////////////////////////////

   // New fault beats the clear
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dispPf <= dispNone;
      else if (clken)
      begin
         if (pageFail)
            dispPf <= dispatch;
         else if (specMemClr)
            dispPf <= dispNone;
      end
   end

endmodule

`default_nettype wire

//--- source/pfTop.sv
`timescale 1ns/1ps
`default_nettype none

module pfTop
#(
   parameter int pageBits = 4
)
(
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  clken,
   // Memory request from microcode
   input  wire                  memCycle,
   input  wire                  memFetch,
   input  wire                  memWrTest,
   input  wire                  memPhys,
   input  wire                  memUser,
   input  wire                  memAcRef,
   input  wire [pageBits-1:0]   vmaPage,
   input  wire                  specMemClr,
   // Interrupts
   input  wire                  piIntr,
   input  wire                  timerIntr,
   input  wire                  nxmIntr,
   // APB
   input  wire                  psel,
   input  wire                  penable,
   input  wire                  pwrite,
   input  wire pfPkg::aprAddrT  paddr,
   input  wire [31:0]           pwdata,
   output logic [31:0]          prdata,
   output logic                 pready,
   // Dispatch to microcode
   output logic                 pageFail,
   output pfPkg::dispCodeT      dispPf
);

   import pfPkg::*;

   logic                pageEnable;
   logic                intrEn;
   logic [pageBits-1:0] pageIdx;
   logic                tableWe;
   logic [pageBits-1:0] tableIdx;
   pageFlagsT           tableFlags;

   // VMA side to dispatch
   pagerIf pagerBus ();

   vmaLatch #(.pageBits(pageBits)) vmaLatch_i
   (
      .clk, .rst, .clken, .memCycle, .memFetch, .memWrTest, .memPhys, .memUser,
      .memAcRef, .vmaPage, .pageIdx, .intrEn, .pb(pagerBus)
   );

   pageTable #(.pageBits(pageBits)) pageTable_i
   (
      .clk, .rst, .pageIdx, .tableWe, .tableIdx, .tableFlags, .pb(pagerBus)
   );

   aprRegs #(.pageBits(pageBits)) aprRegs_i
   (
      .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
      .dispPf, .pageEnable, .tableWe, .tableIdx, .tableFlags
   );

   pageFailDispatch pageFailDispatch_i
   (
      .clk, .rst, .clken, .specMemClr, .pageEnable, .intrEn, .piIntr, .timerIntr,
      .nxmIntr, .pb(pagerBus), .pageFail, .dispPf
   );

endmodule

`default_nettype wire

//--- tests/pfTop_properties.sv
`timescale 1ns/1ps
`default_nettype none

module pfTop_properties
(
   input wire        clk,
   input wire        rst,
   input wire        clken,
   input wire        pfEn,
   input wire        intrEn,
   input wire        pageFail,
   input wire [3:0]  dispPf,
   input wire        psel,
   input wire        penable,
   input wire        pwrite,
   input wire [7:0]  paddr,
   input wire [31:0] prdata
);

   import pfPkg::*;

   logic unmappedRead;

   // Assertion failures so far
   int   failCount = 0;

   // Read access phase outside the register map
   assign unmappedRead = psel & penable & !pwrite &
                         (paddr != regAprFlags) & (paddr != regDispatch);

   // No fault without a latched request or a fetch behind it
   noStrayFail: assert property (@(posedge clk) disable iff (rst)
      !pfEn && !intrEn |-> !pageFail)
      else
      begin
         failCount++;
         $error("pageFail raised with no request pending");
      end

   unmappedZero: assert property (@(posedge clk) disable iff (rst)
      unmappedRead |-> prdata == 32'd0)
      else
      begin
         failCount++;
         $error("unmapped APB read returned nonzero data");
      end

   // Frozen while clken is low
   dispHold: assert property (@(posedge clk) disable iff (rst)
      !clken |=> $stable(dispPf))
      else
      begin
         failCount++;
         $error("dispPf changed on a disabled edge");
      end

endmodule

`default_nettype wire

//--- tests/pfTb.sv
`timescale 1ns/1ps
`default_nettype none

module pfTb;

   import pfPkg::*;

   // Narrow table, so index i+8 falls outside the page window
   localparam int pageBits   = 3;
   localparam int numPages   = 1 << pageBits;
   localparam int numRows    = 15;
   localparam int cycleLimit = numRows * 12 + 200;

   typedef struct packed
   {
      logic       fetch, wrTest, phys, user, acRef;
      logic [3:0] page;
      logic       pi, timer, nxm;
      logic       pgEn, clr, hold;
      logic [3:0] code;
   } rowT;

   // fetch wrTest phys user acRef page | pi timer nxm | pgEn clr hold | code
   rowT rows [numRows] = '{
      '{1, 0, 0, 0, 0, 4'd0, 1, 0, 1, 0, 0, 0, 4'd5},   // NXM beats PI
      '{1, 0, 0, 0, 0, 4'd0, 1, 0, 0, 0, 0, 0, 4'd1},
      '{1, 0, 0, 0, 0, 4'd0, 0, 1, 0, 0, 0, 0, 4'd1},
      '{0, 0, 0, 0, 0, 4'd0, 1, 1, 1, 0, 0, 0, 4'd0},   // no fetch
      '{0, 0, 0, 0, 0, 4'd1, 0, 0, 0, 1, 0, 0, 4'd10},  // also alias check
      '{0, 1, 0, 0, 0, 4'd2, 0, 0, 0, 1, 0, 0, 4'd11},
      '{0, 1, 0, 0, 0, 4'd3, 0, 0, 0, 1, 0, 0, 4'd8},
      '{0, 1, 0, 1, 0, 4'd4, 0, 0, 0, 1, 0, 0, 4'd0},
      '{0, 0, 1, 0, 0, 4'd1, 0, 0, 0, 1, 0, 0, 4'd0},   // physical
      '{0, 0, 0, 0, 1, 4'd1, 0, 0, 0, 1, 0, 0, 4'd0},   // AC reference
      '{0, 0, 0, 0, 0, 4'd1, 0, 0, 0, 0, 0, 0, 4'd0},   // paging off
      '{0, 0, 0, 0, 0, 4'd1, 0, 0, 0, 1, 0, 1, 4'd10},  // hold
      '{0, 1, 0, 1, 0, 4'd4, 0, 0, 0, 1, 1, 0, 4'd0},   // clear
      '{0, 1, 0, 0, 0, 4'd3, 0, 0, 0, 1, 1, 0, 4'd8},   // fault beats clear
      '{0, 0, 1, 0, 0, 4'd1, 0, 0, 0, 1, 1, 0, 4'd0}
   };

   logic                clk, rst, clken, memCycle, memFetch, memWrTest;
   logic                memPhys, memUser, memAcRef, specMemClr;
   logic                piIntr, timerIntr, nxmIntr, psel, penable, pwrite;
   logic [pageBits-1:0] vmaPage;
   aprAddrT             paddr;
   logic [31:0]         pwdata, prdata, data;
   logic                pready, pageFail;
   dispCodeT            dispPf;
   logic [7:0]          lfsr;
   logic [2:0]          mirror [numPages];
   logic [3:0]          expDisp;
   int                  errors = 0;
   int                  rowErr = 0;
   int                  cycles = 0;

   pfTop #(.pageBits(pageBits)) pfTop_i (.*);

   bind pfTop pfTop_properties props_i
   (
      .clk, .rst, .clken, .pfEn(pagerBus.pfEn), .intrEn, .pageFail, .dispPf,
      .psel, .penable, .pwrite, .paddr, .prdata
   );

   always #20 clk = ~clk;

   // Run limit
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= cycleLimit)
      begin
         $display("timeout, no finish after %0d cycles", cycles);
         $display("sim failed");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   // x^8 + x^6 + x^5 + x^4 + 1
   function automatic logic [7:0] stepLfsr(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp)
      begin
         errors++;
         rowErr++;
         $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   // Setup, access, idle; read data taken mid access phase
   task automatic apbTransfer(input logic write, input aprAddrT addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
      @(negedge clk);
      psel    = 1'b1;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      #10 rdata = prdata;
      checkValue("pready", pready, 1'b1);
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   initial
   begin
      clk        = 1'b0;
      rst        = 1'b1;
      clken      = 1'b1;
      memCycle   = 1'b0;
      memFetch   = 1'b0;
      memWrTest  = 1'b0;
      memPhys    = 1'b0;
      memUser    = 1'b0;
      memAcRef   = 1'b0;
      vmaPage    = '0;
      specMemClr = 1'b0;
      piIntr     = 1'b0;
      timerIntr  = 1'b0;
      nxmIntr    = 1'b0;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      repeat (8) @(negedge clk);
      rst = 1'b0;
      // Reset state
      #10;
      checkValue("pageFail", pageFail, 0);
      checkValue("dispPf", dispPf, 0);
      apbTransfer(1'b0, regDispatch, 0, data);
      checkValue("regDispatch", data, 0);
      $display("test 0 (reset) %s", rowErr == 0 ? "ok" : "FAIL");
      // Random flags, one LFSR step per bit
      lfsr = 8'd2;
      for (int p = 0; p < numPages; p++)
         for (int b = 0; b < 3; b++)
         begin
            lfsr = stepLfsr(lfsr);
            mirror[p][b] = lfsr[0];
         end
      // Pin the bits the fault rows rely on
      mirror[1][2] = 1'b0;
      mirror[2][2] = 1'b1;
      mirror[2][0] = 1'b1;
      mirror[3]    = 3'b100;
      mirror[4]    = 3'b111;
      for (int p = 0; p < numPages; p++)
         apbTransfer(1'b1, aprAddrT'(pageBase + 4 * p), {29'd0, mirror[p]}, data);
      // Past the window, entry 1 must stay invalid
      apbTransfer(1'b1, aprAddrT'(pageBase + 4 * (numPages + 1)), 32'd7, data);
      // Unmapped read past the window, on top of the valid entry 4
      rowErr = 0;
      apbTransfer(1'b0, aprAddrT'(pageBase + 4 * (numPages + 4)), 0, data);
      checkValue("prdata", data, 0);
      $display("test unmapped read %s", rowErr == 0 ? "ok" : "FAIL");
      expDisp = 4'd0;
      for (int r = 0; r < numRows; r++)
      begin
         rowErr = 0;
         apbTransfer(1'b1, regAprFlags, {31'd0, rows[r].pgEn}, data);
         // Cycle N, request
         @(negedge clk);
         memCycle  = 1'b1;
         memFetch  = rows[r].fetch;
         memWrTest = rows[r].wrTest;
         memPhys   = rows[r].phys;
         memUser   = rows[r].user;
         memAcRef  = rows[r].acRef;
         vmaPage   = rows[r].page[pageBits-1:0];
         // Cycle N+1, interrupts only count here
         @(negedge clk);
         memCycle   = 1'b0;
         piIntr     = rows[r].pi;
         timerIntr  = rows[r].timer;
         nxmIntr    = rows[r].nxm;
         specMemClr = rows[r].clr;
         #10;
         checkValue("pageFail", pageFail, rows[r].code != 4'd0);
         // Fault first, then clear, else hold
         if (rows[r].code != 4'd0)
            expDisp = rows[r].code;
         else if (rows[r].clr)
            expDisp = 4'd0;
         // Cycle N+2, clear attempted with clken low
         @(negedge clk);
         piIntr     = 1'b0;
         timerIntr  = 1'b0;
         nxmIntr    = 1'b0;
         specMemClr = rows[r].hold;
         clken      = !rows[r].hold;
         if (rows[r].hold)
            repeat (2) @(negedge clk);
         specMemClr = 1'b0;
         clken      = 1'b1;
         #10;
         checkValue("dispPf", dispPf, expDisp);
         apbTransfer(1'b0, regDispatch, 0, data);
         checkValue("regDispatch", data, expDisp);
         $display("test %0d %s", r + 1, rowErr == 0 ? "ok" : "FAIL");
      end
      // Bound assertion failures count too
      errors += pfTop_i.props_i.failCount;
      $display("%0d tests run, %0d errors", numRows + 2, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
common/pfPkg.sv
common/pagerIf.sv
source/vmaLatch.sv
pager/pageTable.sv
source/aprRegs.sv
dispatch/pageFailDispatch.sv
source/pfTop.sv
tests/pfTop_properties.sv
tests/pfTb.sv
